// ==== byte_presence.f ====
verilog/byte_map_pkg.sv
verilog/map_update_if.sv
verilog/byte_slot_counter.sv
verilog/bitmap_bank_array.sv
verilog/map_snapshot.sv
verilog/byte_presence_top.sv
testbench/tb_clock_gen.sv
testbench/tb_byte_presence.sv

// ==== Makefile ====
TOP   = tb_byte_presence
FLIST = byte_presence.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// ==== testbench/tb_byte_presence.sv ====
`timescale 1ns/1ps

module tb_byte_presence
    import byte_map_pkg::*;
();

    localparam int MAP_BITS      = NUM_BANKS * BANK_W;
    localparam int PULSE_TIMEOUT = 40;
    localparam int RAND_ROUNDS   = 40;

    logic       clk;
    logic       rst;
    logic       valid;
    byte_t      data;
    bank_idx_t  rd_addr;
    bank_word_t rd_data;
    logic       map_valid;

    // reference map
    logic [MAP_BITS-1:0] m_work;
    logic [MAP_BITS-1:0] m_pub;
    int                  m_slot;
    int                  m_done_cnt;

    int          cyc;
    int          pulses;
    int          last_pulse_cyc;
    int          last_byte_cyc;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lcg_state;

    tb_clock_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    byte_presence_top u_dut (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_valid     (valid),
        .i_data      (data),
        .i_rd_addr   (rd_addr),
        .o_rd_data   (rd_data),
        .o_map_valid (map_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // random numbers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic byte_t rand_byte();
        logic [31:0] r;
        r = lcg_next();
        return r[31:24];                    // upper bits are the better ones
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = lcg_next() >> 8;
        return int'(r % 32'(n));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    task automatic model_byte(byte_t v);
        int idx;
        idx = int'(v) * 8 + m_slot;         // value * 8 + slot
        m_work[idx] = 1'b1;
        if (m_slot == PKT_BYTES - 1) begin
            m_pub      = m_work;
            m_work     = '0;
            m_done_cnt = m_done_cnt + 1;
            m_slot     = 0;
        end else begin
            m_slot = m_slot + 1;
        end
    endtask

    task automatic model_gap();
        if (m_slot != 0) begin
            m_work = '0;                    // partial packet dropped
        end
        m_slot = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic tick();
        @(negedge clk);
        cyc = cyc + 1;
        if (map_valid) begin
            pulses         = pulses + 1;
            last_pulse_cyc = cyc;
        end
    endtask

    task automatic send_byte(byte_t v);
        tick();
        valid = 1'b1;
        data  = v;
        model_byte(v);
        last_byte_cyc = cyc;
    endtask

    task automatic send_idle();
        tick();
        valid = 1'b0;
        data  = rand_byte();                // junk must not reach the map
        model_gap();
    endtask

    task automatic wait_pulses(int target);
        int n;
        n = 0;
        while (pulses < target && n < PULSE_TIMEOUT) begin
            send_idle();
            n = n + 1;
        end
        if (pulses < target) begin
            $display("Timeout: waited %0d cycles for o_map_valid, saw %0d of %0d pulses",
                     PULSE_TIMEOUT, pulses, target);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic pause_stream();
        repeat (4) send_idle();
    endtask

    task automatic compare_snapshot();
        bank_word_t exp;
        for (int b = 0; b < NUM_BANKS; b++) begin
            send_idle();
            rd_addr = bank_idx_t'(b);
            #2;
            exp = m_pub[b*BANK_W +: BANK_W];
            if (rd_data !== exp) begin
                $display("Error at %0t: bank %0d read %h, expected %h",
                         $time, b, rd_data, exp);
                test_errors = test_errors + 1;
            end
        end
    endtask

    task automatic check_pulse_count(int got, int exp);
        if (got != exp) begin
            $display("Error at %0t: %0d o_map_valid pulses, expected %0d",
                     $time, got, exp);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic finish_test(int num, string name);
        tests_run = tests_run + 1;
        if (test_errors != 0) begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: failed with %0d errors", num, name, test_errors);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
        errors      = errors + test_errors;
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int n;
        int p0;
        int d0;
        int len;
        int last_read;

        valid   = 1'b0;
        data    = '0;
        rd_addr = '0;
        m_work  = '0;
        m_pub   = '0;
        m_slot  = 0;
        m_done_cnt     = 0;
        cyc            = 0;
        pulses         = 0;
        last_pulse_cyc = 0;
        last_byte_cyc  = 0;
        errors         = 0;
        test_errors    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        lcg_state      = 32'd81722;

        n = 0;
        while (rst && n < 100) begin
            @(negedge clk);
            n = n + 1;
        end
        if (rst) begin
            $display("Reset was never released within 100 cycles");
            test_errors = test_errors + 1;
        end

        // 1: nothing published out of reset
        repeat (8) send_idle();
        check_pulse_count(pulses, 0);
        compare_snapshot();
        finish_test(1, "reset state");

        // 2: one packet, latency of two edges
        p0 = pulses;
        repeat (PKT_BYTES) send_byte(rand_byte());
        wait_pulses(p0 + 1);
        pause_stream();
        check_pulse_count(pulses - p0, 1);
        if (pulses > p0 && last_pulse_cyc - last_byte_cyc != 3) begin
            $display("Error at %0t: o_map_valid %0d falling edges after last byte, expected 3",
                     $time, last_pulse_cyc - last_byte_cyc);
            test_errors = test_errors + 1;
        end
        compare_snapshot();
        finish_test(2, "single packet");

        // 3: two packets with no gap
        p0 = pulses;
        repeat (2 * PKT_BYTES) send_byte(rand_byte());
        wait_pulses(p0 + 2);
        pause_stream();
        check_pulse_count(pulses - p0, 2);
        compare_snapshot();
        finish_test(3, "back-to-back packets");

        // 4: partial packet then gap
        p0  = pulses;
        len = 1 + rand_below(PKT_BYTES - 1);
        repeat (len) send_byte(rand_byte());
        pause_stream();
        check_pulse_count(pulses - p0, 0);
        repeat (PKT_BYTES) send_byte(rand_byte());
        wait_pulses(p0 + 1);
        pause_stream();
        check_pulse_count(pulses - p0, 1);
        compare_snapshot();
        finish_test(4, "abort");

        // 5: bursts with random gaps
        p0        = pulses;
        d0        = m_done_cnt;
        last_read = pulses;
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            len = 1 + rand_below(40);
            for (int i = 0; i < len; i++) begin
                if (rand_below(8) == 0) begin
                    send_idle();
                end else begin
                    send_byte(rand_byte());
                end
            end
            pause_stream();
            check_pulse_count(pulses - p0, m_done_cnt - d0);
            if (pulses != last_read) begin
                compare_snapshot();
                last_read = pulses;
            end
        end
        finish_test(5, "random stream");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #4 o_clk = ~o_clk;          // 8 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (8) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;                       // release away from the sampling edge
    end

endmodule

// ==== verilog/byte_presence_top.sv ====
`timescale 1ns/1ps

module byte_presence_top
    import byte_map_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_valid,
    input  byte_t      i_data,
    input  bank_idx_t  i_rd_addr,
    output bank_word_t o_rd_data,
    output logic       o_map_valid
);

    bank_word_t map_w [NUM_BANKS];
    logic       publish_w;

    map_update_if u_upd ();

    //////////////////////////////////////////////////////////////////////
    // byte in -> slot and control
    //////////////////////////////////////////////////////////////////////
    byte_slot_counter u_slot_counter (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_data  (i_data),
        .upd     (u_upd.src)
    );

    //////////////////////////////////////////////////////////////////////
    // working map, completed on the eighth byte
    //////////////////////////////////////////////////////////////////////
    bitmap_bank_array u_bank_array (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .upd       (u_upd.dst),
        .o_map     (map_w),
        .o_publish (publish_w)
    );

    //////////////////////////////////////////////////////////////////////
    // snapshot and read port
    //////////////////////////////////////////////////////////////////////
    map_snapshot u_snapshot (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_map       (map_w),
        .i_publish   (publish_w),
        .i_rd_addr   (i_rd_addr),
        .o_rd_data   (o_rd_data),
        .o_map_valid (o_map_valid)
    );

endmodule

// ==== verilog/map_snapshot.sv ====
`timescale 1ns/1ps

module map_snapshot
    import byte_map_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  bank_word_t i_map [NUM_BANKS],
    input  logic       i_publish,
    input  bank_idx_t  i_rd_addr,
    output bank_word_t o_rd_data,
    output logic       o_map_valid
);

    bank_word_t snap_q [NUM_BANKS];
    logic       valid_q;

    //////////////////////////////////////////////////////////////////////
    // published map
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                snap_q[b] <= '0;
            end
        end else if (i_publish) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                snap_q[b] <= i_map[b];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_publish;                 // new snapshot pulse
        end
    end

    assign o_rd_data   = snap_q[i_rd_addr];       // async bank read
    assign o_map_valid = valid_q;

endmodule

// ==== verilog/bitmap_bank_array.sv ====
`timescale 1ns/1ps

module bitmap_bank_array
    import byte_map_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    map_update_if.dst  upd,
    output bank_word_t o_map [NUM_BANKS],
    output logic       o_publish
);

    localparam int BIT_W = $clog2(BANK_W);

    bank_word_t       work_q   [NUM_BANKS];
    bank_word_t       work_set [NUM_BANKS];
    bank_word_t       map_q    [NUM_BANKS];
    logic             publish_q;
    bank_idx_t        wr_bank;
    logic [BIT_W-1:0] wr_bit;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////
    assign wr_bank = upd.data[7:3];               // value / 8
    assign wr_bit  = {upd.data[2:0], upd.slot};   // (value mod 8) * 8 + slot

    // working banks with the current byte merged in
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            work_set[b] = work_q[b];
            if (upd.wr && wr_bank == bank_idx_t'(b)) begin
                work_set[b][wr_bit] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // working map
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst || upd.done || upd.abort) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                work_q[b] <= '0;                  // eighth bit lands in map_q only
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                work_q[b] <= work_set[b];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // completed map and publish strobe
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (upd.done) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                map_q[b] <= work_set[b];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            publish_q <= 1'b0;
        end else begin
            publish_q <= upd.done;                // one cycle per packet
        end
    end

    assign o_map     = map_q;
    assign o_publish = publish_q;

    // an aborted packet must never reach the snapshot
    a_no_publish_after_abort: assert property (
        @(posedge i_clk) disable iff (i_rst)
        upd.abort |=> !o_publish
    );

endmodule

// ==== verilog/byte_slot_counter.sv ====
`timescale 1ns/1ps

module byte_slot_counter
    import byte_map_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_valid,
    input  byte_t     i_data,
    map_update_if.src upd
);

    localparam slot_t LAST_SLOT = slot_t'(PKT_BYTES - 1);

    slot_state_e state_q;
    slot_t       slot_q;
    logic        last_w;

    assign last_w = (slot_q == LAST_SLOT);

    //////////////////////////////////////////////////////////////////////
    // packet framing
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= S_IDLE;
            slot_q  <= '0;
        end else if (i_valid) begin
            slot_q  <= slot_q + slot_t'(1);         // wraps 7 -> 0, no dead cycle
            state_q <= last_w ? S_IDLE : S_IN_PKT;
        end else begin
            slot_q  <= '0;                          // gap restarts framing
            state_q <= S_IDLE;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered update towards the bank array
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            upd.wr    <= 1'b0;
            upd.done  <= 1'b0;
            upd.abort <= 1'b0;
        end else begin
            upd.wr    <= i_valid;
            upd.done  <= i_valid && last_w;
            upd.abort <= !i_valid && (state_q == S_IN_PKT); // partial packet
        end
    end

    always_ff @(posedge i_clk) begin
        upd.data <= i_data;
        upd.slot <= slot_q;
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    // done closes a run of eight writes that began at slot 0
    a_done_last_slot: assert property (
        @(posedge i_clk) disable iff (i_rst)
        upd.done |-> (upd.slot == LAST_SLOT &&
                      $past(upd.wr && upd.slot == '0, PKT_BYTES - 1))
    );

    // abort only after a write that left its packet open
    a_abort_framing: assert property (
        @(posedge i_clk) disable iff (i_rst)
        upd.abort |-> (!upd.wr && $past(upd.wr && !upd.done))
    );

endmodule

// ==== verilog/map_update_if.sv ====
`timescale 1ns/1ps

interface map_update_if
    import byte_map_pkg::*;
();

    logic  wr;     // byte to be written
    byte_t data;
    slot_t slot;
    logic  done;   // eighth byte of the packet
    logic  abort;  // gap inside a packet

    modport src (
        output wr,
        output data,
        output slot,
        output done,
        output abort
    );

    modport dst (
        input wr,
        input data,
        input slot,
        input done,
        input abort
    );

endinterface

// ==== verilog/byte_map_pkg.sv ====
package byte_map_pkg;

    //////////////////////////////////////////////////////////////////////
    // map geometry, tied to the 8-bit byte
    //////////////////////////////////////////////////////////////////////
    localparam int PKT_BYTES = 8;     // bytes per packet
    localparam int NUM_BANKS = 32;    // 256 values / 8 per bank
    localparam int BANK_W    = 64;    // 8 values x 8 slots

    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  slot_t;      // position inside a packet
    typedef logic [4:0]  bank_idx_t;  // upper five byte bits
    typedef logic [63:0] bank_word_t;

    // packet framing
    typedef enum logic {
        S_IDLE,
        S_IN_PKT
    } slot_state_e;

endpackage
